// ==== hdl/ooo_core_consts.svh ====
`ifndef OOO_CORE_CONSTS_SVH
`define OOO_CORE_CONSTS_SVH

// data path width
`define OOO_XLEN 32

// register spaces
`define OOO_NUM_ARCH 32
`define OOO_NUM_PHYS 64

// window sizes, both powers of two
`define OOO_RS_DEPTH 8
`define OOO_ROB_DEPTH 16

`endif

// ==== hdl/ooo_core_pkg.sv ====
`default_nettype none

`include "ooo_core_consts.svh"

package ooo_core_pkg;

    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [$clog2(`OOO_NUM_ARCH)-1:0] arch_reg_t;
    typedef logic [$clog2(`OOO_NUM_PHYS)-1:0] phys_tag_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;  // also serves as the op tag

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT   // signed compare
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module rename_stage (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     alloc,
    input  wire ooo_core_pkg::arch_reg_t  rs1, rs2, rd,
    output ooo_core_pkg::phys_tag_t       src1_tag, src2_tag,
    output logic                          src1_zero, src2_zero,
    output ooo_core_pkg::phys_tag_t       dest_tag, old_tag,
    output logic                          free_empty,
    input  wire logic                     free_valid,
    input  wire ooo_core_pkg::phys_tag_t  free_tag
);

    localparam int FREE_N = `OOO_NUM_PHYS - `OOO_NUM_ARCH;
    localparam int PTR_W  = $clog2(FREE_N);

    ooo_core_pkg::phys_tag_t rat [`OOO_NUM_ARCH];
    ooo_core_pkg::phys_tag_t free_list [FREE_N];
    logic [PTR_W-1:0]        free_head;
    logic [PTR_W-1:0]        free_tail;
    logic [PTR_W:0]          free_count;

    assign src1_tag   = rat[rs1];
    assign src2_tag   = rat[rs2];
    assign src1_zero  = (rs1 == '0);
    assign src2_zero  = (rs2 == '0);
    assign dest_tag   = free_list[free_head];  // popped on alloc
    assign old_tag    = rat[rd];
    assign free_empty = (free_count == '0);

    // identity map with the upper tags free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_ARCH; i++) begin
                rat[i] <= ooo_core_pkg::phys_tag_t'(i);
            end
            for (int i = 0; i < FREE_N; i++) begin
                free_list[i] <= ooo_core_pkg::phys_tag_t'(i + `OOO_NUM_ARCH);
            end
            free_head  <= '0;
            free_tail  <= '0;
            free_count <= FREE_N[PTR_W:0];
        end else begin
            if (alloc) begin
                free_head <= free_head + 1'b1;
                if (rd != '0) begin
                    rat[rd] <= dest_tag;  // x0 keeps tag 0
                end
            end
            if (free_valid) begin
                free_list[free_tail] <= free_tag;
                free_tail            <= free_tail + 1'b1;
            end
            case ({free_valid, alloc})
                2'b10:   free_count <= free_count + 1'b1;
                2'b01:   free_count <= free_count - 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phys_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module phys_regfile (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     alloc,
    input  wire ooo_core_pkg::phys_tag_t  dest_tag,
    input  wire ooo_core_pkg::phys_tag_t  rd_tag1, rd_tag2,
    output ooo_core_pkg::word_t           rd_value1, rd_value2,
    output logic                          rd_ready1, rd_ready2,
    input  wire logic                     cdb_valid,
    input  wire ooo_core_pkg::phys_tag_t  cdb_tag,
    input  wire ooo_core_pkg::word_t      cdb_value
);

    ooo_core_pkg::word_t      values [`OOO_NUM_PHYS];
    logic [`OOO_NUM_PHYS-1:0] ready;
    logic                     hit1;
    logic                     hit2;

    // result bus bypass into the dispatch reads
    assign hit1      = cdb_valid && (cdb_tag == rd_tag1);
    assign hit2      = cdb_valid && (cdb_tag == rd_tag2);
    assign rd_value1 = hit1 ? cdb_value : values[rd_tag1];
    assign rd_value2 = hit2 ? cdb_value : values[rd_tag2];
    assign rd_ready1 = hit1 | ready[rd_tag1];
    assign rd_ready2 = hit2 | ready[rd_tag2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_PHYS; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < `OOO_NUM_ARCH);  // initial mappings hold zero
            end
        end else begin
            if (alloc) begin
                ready[dest_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                values[cdb_tag] <= cdb_value;
                ready[cdb_tag]  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reservation_station.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module reservation_station (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     disp_write,
    input  wire ooo_core_pkg::alu_op_t    disp_op,
    input  wire ooo_core_pkg::word_t      disp_imm,
    input  wire logic                     disp_use_imm,
    input  wire ooo_core_pkg::word_t      src1_value, src2_value,
    input  wire logic                     src1_ready, src2_ready,
    input  wire ooo_core_pkg::phys_tag_t  src1_tag, src2_tag, dest_tag,
    input  wire ooo_core_pkg::rob_idx_t   disp_rob_idx,
    output logic                          full,
    output logic                          issue_valid,
    output ooo_core_pkg::alu_op_t         issue_op,
    output ooo_core_pkg::word_t           issue_a, issue_b,
    output ooo_core_pkg::phys_tag_t       issue_tag,
    output ooo_core_pkg::rob_idx_t        issue_rob_idx,
    input  wire logic                     cdb_valid,
    input  wire ooo_core_pkg::phys_tag_t  cdb_tag,
    input  wire ooo_core_pkg::word_t      cdb_value
);

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0]        valid;
    logic [DEPTH-1:0]        rdy1;
    logic [DEPTH-1:0]        rdy2;
    logic [DEPTH-1:0]        use_imm;
    logic [DEPTH-1:0]        older [DEPTH];  // bit j set when entry j is older
    ooo_core_pkg::alu_op_t   op [DEPTH];
    ooo_core_pkg::word_t     val1 [DEPTH];
    ooo_core_pkg::word_t     val2 [DEPTH];
    ooo_core_pkg::word_t     imm [DEPTH];
    ooo_core_pkg::phys_tag_t tag1 [DEPTH];
    ooo_core_pkg::phys_tag_t tag2 [DEPTH];
    ooo_core_pkg::phys_tag_t dest [DEPTH];
    ooo_core_pkg::rob_idx_t  rob_idx [DEPTH];
    logic [DEPTH-1:0]        req;
    logic [IDX_W-1:0]        free_idx;
    logic [IDX_W-1:0]        sel;

    assign full = &valid;
    assign req  = valid & rdy1 & (rdy2 | use_imm);

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // oldest ready entry, no older requester may exist
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (req[i] && ((req & older[i]) == '0)) begin
                issue_valid = 1'b1;
                sel         = IDX_W'(i);
            end
        end
    end

    assign issue_op      = op[sel];
    assign issue_a       = val1[sel];
    assign issue_b       = use_imm[sel] ? imm[sel] : val2[sel];
    assign issue_tag     = dest[sel];
    assign issue_rob_idx = rob_idx[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[sel] <= 1'b0;  // freed at issue
            end
            if (disp_write) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (cdb_valid && !rdy1[i] && (tag1[i] == cdb_tag)) begin
                val1[i] <= cdb_value;
                rdy1[i] <= 1'b1;
            end
            if (cdb_valid && !rdy2[i] && (tag2[i] == cdb_tag)) begin
                val2[i] <= cdb_value;
                rdy2[i] <= 1'b1;
            end
        end
        if (disp_write) begin
            op[free_idx]      <= disp_op;
            imm[free_idx]     <= disp_imm;
            use_imm[free_idx] <= disp_use_imm;
            val1[free_idx]    <= src1_value;
            val2[free_idx]    <= src2_value;
            rdy1[free_idx]    <= src1_ready;
            rdy2[free_idx]    <= src2_ready;
            tag1[free_idx]    <= src1_tag;
            tag2[free_idx]    <= src2_tag;
            dest[free_idx]    <= dest_tag;
            rob_idx[free_idx] <= disp_rob_idx;
            older[free_idx]   <= valid;  // everything already waiting is older
            for (int j = 0; j < DEPTH; j++) begin
                older[j][free_idx] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/int_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_alu (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     issue_valid,
    input  wire ooo_core_pkg::alu_op_t    issue_op,
    input  wire ooo_core_pkg::word_t      issue_a, issue_b,
    input  wire ooo_core_pkg::phys_tag_t  issue_tag,
    input  wire ooo_core_pkg::rob_idx_t   issue_rob_idx,
    output logic                          cdb_valid,
    output ooo_core_pkg::phys_tag_t       cdb_tag,
    output ooo_core_pkg::rob_idx_t        cdb_rob_idx,
    output ooo_core_pkg::word_t           cdb_value
);

    ooo_core_pkg::word_t result;

    always_comb begin
        case (issue_op)
            ooo_core_pkg::ALU_ADD: result = issue_a + issue_b;
            ooo_core_pkg::ALU_SUB: result = issue_a - issue_b;
            ooo_core_pkg::ALU_AND: result = issue_a & issue_b;
            ooo_core_pkg::ALU_OR:  result = issue_a | issue_b;
            ooo_core_pkg::ALU_XOR: result = issue_a ^ issue_b;
            ooo_core_pkg::ALU_SLL: result = issue_a << issue_b[4:0];
            ooo_core_pkg::ALU_SRL: result = issue_a >> issue_b[4:0];  // logical
            ooo_core_pkg::ALU_SLT: begin
                result = ooo_core_pkg::word_t'($signed(issue_a) < $signed(issue_b));
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_tag     <= issue_tag;
            cdb_rob_idx <= issue_rob_idx;
            cdb_value   <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module reorder_buffer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     alloc,
    input  wire ooo_core_pkg::arch_reg_t  alloc_rd,
    input  wire ooo_core_pkg::phys_tag_t  alloc_dest_tag, alloc_old_tag,
    output ooo_core_pkg::rob_idx_t        alloc_idx,
    output logic                          full,
    input  wire logic                     cdb_valid,
    input  wire ooo_core_pkg::rob_idx_t   cdb_rob_idx,
    input  wire ooo_core_pkg::word_t      cdb_value,
    output logic                          commit_valid,
    input  wire logic                     commit_ready,
    output ooo_core_pkg::arch_reg_t       commit_rd,
    output ooo_core_pkg::word_t           commit_value,
    output logic                          free_valid,
    output ooo_core_pkg::phys_tag_t       free_tag
);

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ooo_core_pkg::arch_reg_t slot_rd [DEPTH];
    ooo_core_pkg::phys_tag_t slot_dest [DEPTH];
    ooo_core_pkg::phys_tag_t slot_old [DEPTH];
    ooo_core_pkg::word_t     slot_value [DEPTH];
    logic [DEPTH-1:0]        slot_done;
    ooo_core_pkg::rob_idx_t  head;
    ooo_core_pkg::rob_idx_t  tail;
    logic [CNT_W-1:0]        count;

    assign alloc_idx    = tail;
    assign full         = (count == DEPTH[CNT_W-1:0]);
    assign commit_valid = (count != '0) && slot_done[head];
    assign commit_rd    = slot_rd[head];
    assign commit_value = slot_value[head];
    assign free_valid   = commit_valid && commit_ready;
    // x0 never took its tag into the table, so hand back its own
    assign free_tag     = (slot_rd[head] == '0) ? slot_dest[head] : slot_old[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
        end else begin
            if (alloc) begin
                slot_done[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (cdb_valid) begin
                slot_done[cdb_rob_idx] <= 1'b1;
            end
            if (free_valid) begin
                head <= head + 1'b1;
            end
            case ({alloc, free_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_rd[tail]   <= alloc_rd;
            slot_dest[tail] <= alloc_dest_tag;
            slot_old[tail]  <= alloc_old_tag;
        end
        if (cdb_valid) begin
            slot_value[cdb_rob_idx] <= cdb_value;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module ooo_core (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     disp_valid,
    output logic                          disp_ready,
    input  wire ooo_core_pkg::alu_op_t    disp_op,
    input  wire ooo_core_pkg::arch_reg_t  disp_rd, disp_rs1, disp_rs2,
    input  wire ooo_core_pkg::word_t      disp_imm,
    input  wire logic                     disp_use_imm,
    output logic                          commit_valid,
    input  wire logic                     commit_ready,
    output ooo_core_pkg::arch_reg_t       commit_rd,
    output ooo_core_pkg::word_t           commit_value
);

    logic                    accept;
    logic                    free_empty;
    logic                    rs_full;
    logic                    rob_full;
    ooo_core_pkg::phys_tag_t src1_tag, src2_tag, dest_tag, old_tag;
    logic                    src1_zero, src2_zero;
    ooo_core_pkg::word_t     rd_value1, rd_value2;
    logic                    rd_ready1, rd_ready2;
    ooo_core_pkg::word_t     op1_value, op2_value;
    logic                    op1_ready, op2_ready;
    ooo_core_pkg::rob_idx_t  rob_idx;
    logic                    free_valid;
    ooo_core_pkg::phys_tag_t free_tag;
    logic                    issue_valid;
    ooo_core_pkg::alu_op_t   issue_op;
    ooo_core_pkg::word_t     issue_a, issue_b;
    ooo_core_pkg::phys_tag_t issue_tag;
    ooo_core_pkg::rob_idx_t  issue_rob_idx;
    logic                    cdb_valid;
    ooo_core_pkg::phys_tag_t cdb_tag;
    ooo_core_pkg::rob_idx_t  cdb_rob_idx;
    ooo_core_pkg::word_t     cdb_value;

    assign disp_ready = !free_empty && !rob_full && !rs_full;
    assign accept     = disp_valid && disp_ready;

    // x0 sources enter the station already resolved
    assign op1_value = src1_zero ? '0 : rd_value1;
    assign op2_value = src2_zero ? '0 : rd_value2;
    assign op1_ready = src1_zero | rd_ready1;
    assign op2_ready = src2_zero | rd_ready2;

    rename_stage u_rename (
        .clk(clk), .rst_n(rst_n), .alloc(accept),
        .rs1(disp_rs1), .rs2(disp_rs2), .rd(disp_rd),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_zero(src1_zero), .src2_zero(src2_zero),
        .dest_tag(dest_tag), .old_tag(old_tag), .free_empty(free_empty),
        .free_valid(free_valid), .free_tag(free_tag)
    );

    phys_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .alloc(accept), .dest_tag(dest_tag),
        .rd_tag1(src1_tag), .rd_tag2(src2_tag),
        .rd_value1(rd_value1), .rd_value2(rd_value2),
        .rd_ready1(rd_ready1), .rd_ready2(rd_ready2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    reservation_station u_rs (
        .clk(clk), .rst_n(rst_n), .disp_write(accept),
        .disp_op(disp_op), .disp_imm(disp_imm), .disp_use_imm(disp_use_imm),
        .src1_value(op1_value), .src2_value(op2_value),
        .src1_ready(op1_ready), .src2_ready(op2_ready),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(dest_tag),
        .disp_rob_idx(rob_idx), .full(rs_full),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_tag(issue_tag), .issue_rob_idx(issue_rob_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    int_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_tag(issue_tag), .issue_rob_idx(issue_rob_idx),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_rob_idx(cdb_rob_idx), .cdb_value(cdb_value)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst_n(rst_n), .alloc(accept), .alloc_rd(disp_rd),
        .alloc_dest_tag(dest_tag), .alloc_old_tag(old_tag),
        .alloc_idx(rob_idx), .full(rob_full),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_value(cdb_value),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_rd(commit_rd), .commit_value(commit_value),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

`default_nettype wire

// ==== tb/commit_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_checker (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                disp_valid,
    input  wire logic                disp_ready,
    input  wire logic [4:0]          disp_rd,
    input  wire ooo_core_pkg::word_t exp_value,
    input  wire logic [127:0]        test_label,
    input  wire logic                commit_valid,
    input  wire logic                commit_ready,
    input  wire logic [4:0]          commit_rd,
    input  wire ooo_core_pkg::word_t commit_value,
    output int                       errors,
    output int                       commits,
    output int                       pending
);

    // expected commits in dispatch order
    logic [4:0]          rd_q [$];
    ooo_core_pkg::word_t value_q [$];
    logic [127:0]        label_q [$];

    // a handshake seen mid-cycle completes on the next rising edge
    always @(negedge clk) begin
        logic [4:0]          want_rd;
        ooo_core_pkg::word_t want_value;
        logic [127:0]        label;
        if (!rst_n) begin
            rd_q.delete();
            value_q.delete();
            label_q.delete();
            errors  = 0;
            commits = 0;
        end else begin
            if (commit_valid && commit_ready) begin
                if (rd_q.size() == 0) begin
                    $display("Commit of rd %0d seen with no operation outstanding", commit_rd);
                    errors = errors + 1;
                end else begin
                    want_rd    = rd_q.pop_front();
                    want_value = value_q.pop_front();
                    label      = label_q.pop_front();
                    if (commit_rd !== want_rd || commit_value !== want_value) begin
                        $display("Error: %0s commit %0d expected x%0d=%h actual x%0d=%h",
                                 label, commits, want_rd, want_value, commit_rd, commit_value);
                        errors = errors + 1;
                    end
                end
                commits = commits + 1;
            end
            if (disp_valid && disp_ready) begin
                rd_q.push_back(disp_rd);
                value_q.push_back(exp_value);
                label_q.push_back(test_label);
            end
        end
        pending = rd_q.size();
    end

endmodule

`default_nettype wire

// ==== tb/tb_ooo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ooo_core_consts.svh"

module tb_ooo_core;

    localparam int NUM_OPS = 26;   // operation lines in the stimulus file
    localparam int COLS    = 7;
    localparam int LIMIT   = 200;  // cycles without progress

    logic                  clk;
    logic                  rst_n;
    logic                  disp_valid;
    logic                  disp_ready;
    ooo_core_pkg::alu_op_t disp_op;
    logic [4:0]            disp_rd, disp_rs1, disp_rs2;
    ooo_core_pkg::word_t   disp_imm;
    logic                  disp_use_imm;
    logic                  commit_valid;
    logic                  commit_ready;
    logic [4:0]            commit_rd;
    ooo_core_pkg::word_t   commit_value;
    ooo_core_pkg::word_t   exp_value;
    logic [127:0]          test_label;
    int                    chk_errors, commits, pending;
    int                    tb_errors;
    int                    reported_errors;
    int                    test_num;
    bit                    timed_out;
    logic [31:0]           rng;
    ooo_core_pkg::word_t   stim [NUM_OPS*COLS];

    ooo_core uut (
        .clk(clk), .rst_n(rst_n), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .disp_op(disp_op), .disp_rd(disp_rd), .disp_rs1(disp_rs1), .disp_rs2(disp_rs2),
        .disp_imm(disp_imm), .disp_use_imm(disp_use_imm),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_rd(commit_rd), .commit_value(commit_value)
    );

    commit_checker commit_check (
        .clk(clk), .rst_n(rst_n), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .disp_rd(disp_rd), .exp_value(exp_value), .test_label(test_label),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_rd(commit_rd), .commit_value(commit_value),
        .errors(chk_errors), .commits(commits), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic present(input int idx);
        disp_op      <= ooo_core_pkg::alu_op_t'(stim[idx*COLS][2:0]);
        disp_rd      <= stim[idx*COLS+1][4:0];
        disp_rs1     <= stim[idx*COLS+2][4:0];
        disp_rs2     <= stim[idx*COLS+3][4:0];
        disp_imm     <= stim[idx*COLS+4];
        disp_use_imm <= stim[idx*COLS+5][0];
        exp_value    <= stim[idx*COLS+6];
        disp_valid   <= 1'b1;
    endtask

    // mode 0 always ready, mode 2 random stalls; mode 1 is handled in run_ops
    task automatic drive_commit_ready(input int mode);
        if (mode == 0) begin
            commit_ready <= 1'b1;
        end else if (mode == 2) begin
            rng = xorshift32(rng);
            commit_ready <= (rng[1:0] != 2'b00);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic run_ops(input int lo, input int hi, input int mode);
        int idx;
        int idle;
        int acc;
        int low_cycles;
        bit stalled;
        bit accepted;
        idx        = lo;
        idle       = 0;
        acc        = 0;
        low_cycles = 0;
        stalled    = (mode == 1);
        @(posedge clk);
        if (stalled) begin
            commit_ready <= 1'b0;
        end
        present(idx);
        while (idx < hi && !timed_out) begin
            @(negedge clk);
            accepted = disp_valid && disp_ready;
            if (stalled) begin
                acc        = acc + int'(accepted);
                low_cycles = disp_ready ? 0 : low_cycles + 1;
            end
            @(posedge clk);
            idle = accepted ? 0 : idle + 1;
            if (accepted) begin
                idx++;
            end
            if (stalled && low_cycles >= 20) begin  // ROB has been full for a while
                if (acc != `OOO_ROB_DEPTH) begin
                    $display("Error: %0s accepted while stalled, expected %0d actual %0d",
                             test_label, `OOO_ROB_DEPTH, acc);
                    tb_errors++;
                end
                commit_ready <= 1'b1;
                stalled = 1'b0;
            end else if (!stalled) begin
                drive_commit_ready(mode);
            end
            if (accepted || !disp_valid) begin
                rng = xorshift32(rng);
                if (idx < hi && !(mode == 2 && rng[5:4] == 2'b00)) begin
                    present(idx);
                end else begin
                    disp_valid <= 1'b0;
                end
            end
            if (idle > LIMIT) begin
                give_up("dispatch made no progress");
            end
        end
        if (stalled && !timed_out) begin
            $display("disp_ready never fell while commits were held back");
            tb_errors++;
            commit_ready <= 1'b1;
        end
    endtask

    task automatic drain(input int mode);
        int waited;
        waited = 0;
        while (pending != 0 && !timed_out) begin
            @(posedge clk);
            drive_commit_ready(mode);
            waited++;
            if (waited > LIMIT) begin
                give_up("dispatched operations never committed");
            end
        end
        if (!timed_out) begin
            @(negedge clk);
            if (commit_valid !== 1'b0) begin
                $display("commit_valid stayed high after every dispatched operation committed");
                tb_errors++;
            end
        end
    endtask

    task automatic run_test(input logic [127:0] name, input int lo, input int hi,
                            input int mode, input int passes);
        int commits_before;
        int errs;
        commits_before = commits;
        test_label     = name;
        test_num++;
        for (int p = 0; p < passes; p++) begin
            run_ops(lo, hi, mode);
        end
        drain(mode);
        if (!timed_out && commits - commits_before != passes * (hi - lo)) begin
            $display("Error: %0s commit count, expected %0d actual %0d",
                     name, passes * (hi - lo), commits - commits_before);
            tb_errors++;
        end
        errs            = tb_errors + chk_errors - reported_errors;
        reported_errors = tb_errors + chk_errors;
        if (timed_out) begin
            $display("test %0d %0s: not completed", test_num, name);
        end else begin
            $display("test %0d %0s: %0d errors", test_num, name, errs);
        end
    endtask

    initial begin
        int total;
        rst_n           = 1'b0;
        disp_valid      = 1'b0;
        disp_op         = ooo_core_pkg::ALU_ADD;
        disp_rd         = '0;
        disp_rs1        = '0;
        disp_rs2        = '0;
        disp_imm        = '0;
        disp_use_imm    = 1'b0;
        commit_ready    = 1'b1;
        exp_value       = '0;
        test_label      = "reset";
        tb_errors       = 0;
        reported_errors = 0;
        test_num        = 0;
        timed_out       = 1'b0;
        rng             = 32'h37bb_2fd5;
        $readmemh("tb/ooo_core_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (commit_valid !== 1'b0 || disp_ready !== 1'b1) begin
            $display("commit_valid or disp_ready has the wrong level after reset");
            tb_errors++;
        end
        run_test("reset_zero", 0, 4, 0, 1);
        run_test("dep_chains", 4, 16, 0, 1);
        run_test("commit_order", 16, NUM_OPS, 0, 1);
        run_test("rob_backpressure", 0, NUM_OPS, 1, 1);
        run_test("random_stalls", 0, NUM_OPS, 2, 3);  // file leaves x1..x6 zero, so it replays
        total = tb_errors + chk_errors;
        $display("%0d tests, %0d operations committed, %0d errors", test_num, commits, total);
        if (total == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/ooo_core_stimulus.txt ====
// hex columns: op rd rs1 rs2 imm use_imm expected_commit_value
// op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt (signed)
0 05 07 09 00000000 0 00000000
3 06 00 00 00000123 1 00000123
0 00 00 00 00000055 1 00000055
0 09 00 00 00000000 0 00000000
0 01 00 00 00000010 1 00000010
5 02 01 00 00000004 1 00000100
1 03 02 01 00000000 0 000000f0
4 04 03 00 0f0f0f0f 1 0f0f0fff
6 04 04 00 00000024 1 00f0f0ff
1 02 00 01 00000000 0 fffffff0
7 03 02 01 00000000 0 00000001
7 05 01 02 00000000 0 00000000
2 04 04 02 00000000 0 00f0f0f0
3 04 04 06 00000000 0 00f0f1f3
5 02 02 03 00000000 0 ffffffe0
0 01 02 04 00000000 0 00f0f1d3
0 05 01 00 00000001 1 00f0f1d4
4 05 05 04 00000000 0 00000027
5 05 05 00 00000008 1 00002700
0 00 05 05 00000000 0 00004e00
2 01 00 00 00000000 0 00000000
3 02 00 00 00000000 0 00000000
4 03 00 00 00000000 0 00000000
5 04 00 00 00000000 0 00000000
6 06 00 00 00000000 0 00000000
7 05 00 00 00000000 0 00000000

// ==== ooo_core.f ====
+incdir+hdl
hdl/ooo_core_pkg.sv
hdl/rename_stage.sv
hdl/phys_regfile.sv
hdl/reservation_station.sv
hdl/int_alu.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
tb/commit_checker.sv
tb/tb_ooo_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= ooo_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
